//--- flist.f
source/camera_stream_pkg.sv
source/csi2_packet_decoder.sv
source/raw10_unpacker.sv
source/pixel_crop.sv
source/exposure_meter.sv
source/camera_stream_top.sv
tb/camera_stream_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the camera stream testbench with Verilator and runs it.
# The run fails when the log holds the testbench's fail message.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module camera_stream_tb \
    -f flist.f \
    -o camera_stream_sim

./obj_dir/camera_stream_sim 2>&1 | tee sim.log

if grep -q "FAIL: see errors above" sim.log; then
    echo "Simulation failed"
    exit 1
fi

echo "Simulation passed"
exit 0

//--- tb/camera_stream_tb.sv
// Directed testbench for the camera receive path.
// Drives short and long packets into the top level from a pixel image,
// builds the expected cropped stream and meter results from that image
// and compares them with the DUT outputs and their timing.

`timescale 1ns/1ps

module camera_stream_tb;

    localparam int PERIOD         = 40;
    localparam int TIMEOUT_CYCLES = 20000;    // Generous bound over all frames
    localparam int MAX_ROWS       = 8;
    localparam int MAX_COLS       = 16;
    localparam logic [5:0] DT_EMBEDDED = 6'h12;  // Any non-RAW10 long packet

    logic                            mipi_byte_clock = 1'b0;
    logic                            mipi_byte_reset_n;
    logic                            sp_enable;
    logic                            lp_av_enable;
    logic                            payload_enable;
    logic [5:0]                      datatype;
    logic [15:0]                     word_count;
    logic [7:0]                      payload;
    camera_stream_pkg::crop_window_t window;
    camera_stream_pkg::pixel_beat_t  pix_out;
    logic [31:0]                     sum;
    logic [21:0]                     count;
    logic [9:0]                      peak;
    logic                            meter_ready;

    logic [9:0] image [0:MAX_ROWS-1][0:MAX_COLS-1];
    logic [9:0] exp_data[$];
    logic       exp_last[$];
    logic [9:0] got_data[$];
    logic       got_last[$];
    logic [63:0] exp_sum;
    int         exp_count;
    logic [9:0] exp_peak;
    int         seed;
    int         cycle_count = 0;
    int         ready_count;
    bit         record_group;
    bit         fv_seen;
    time        group_time;
    time        first_pix_time;
    time        frame_end_time;
    time        ready_time;
    time        fv_fall_time;

    camera_stream_top #(.SUM_WIDTH(32)) camera_stream_top_i (
        .mipi_byte_clock  (mipi_byte_clock),
        .mipi_byte_reset_n(mipi_byte_reset_n),
        .sp_enable_i      (sp_enable),
        .lp_av_enable_i   (lp_av_enable),
        .datatype_i       (datatype),
        .word_count_i     (word_count),
        .payload_enable_i (payload_enable),
        .payload_i        (payload),
        .crop_window_i    (window),
        .pixel_o          (pix_out),
        .sum_o            (sum),
        .count_o          (count),
        .peak_o           (peak),
        .meter_ready_o    (meter_ready)
    );

    always #(PERIOD/2) mipi_byte_clock = ~mipi_byte_clock;

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        assert (expected == actual) else
            fail_run($sformatf("mismatch %s: expected 0x%0h, got 0x%0h", name, expected, actual));
    endtask

    // Output monitor, sampled away from the rising edge
    always @(negedge mipi_byte_clock) begin
        cycle_count = cycle_count + 1;
        if (pix_out.pixel_valid) begin
            got_data.push_back(pix_out.data);
            got_last.push_back(pix_out.line_end);
            if (first_pix_time == 0) first_pix_time = $time;
        end
        if (meter_ready) begin
            ready_count++;
            ready_time = $time;
        end
        if (fv_seen && !pix_out.frame_valid) fv_fall_time = $time;
        fv_seen = pix_out.frame_valid;
        if (cycle_count >= TIMEOUT_CYCLES)
            fail_run($sformatf("timeout: simulation still running after %0d cycles", cycle_count));
    end

    function automatic camera_stream_pkg::crop_window_t make_window(input int xs, input int xe,
                                                                   input int ys, input int ye);
        camera_stream_pkg::crop_window_t w;
        w.x_start = 11'(xs);
        w.x_end   = 11'(xe);
        w.y_start = 11'(ys);
        w.y_end   = 11'(ye);
        return w;
    endfunction

    // RAW10 wire order: four MSB bytes, then the packed LSB pairs
    function automatic logic [7:0] line_byte(input int row, input int b);
        int g;
        int k;
        g = b / 5;
        k = b % 5;
        if (k < 4) return image[row][4*g+k][9:2];
        return {image[row][4*g+3][1:0], image[row][4*g+2][1:0],
                image[row][4*g+1][1:0], image[row][4*g][1:0]};
    endfunction

    task automatic fill_image(input bit random_data);
        logic [31:0] r;
        for (int y = 0; y < MAX_ROWS; y++) begin
            for (int x = 0; x < MAX_COLS; x++) begin
                r = $random(seed);
                image[y][x] = random_data ? r[9:0] : 10'((y * 73 + x * 29 + 3) & 10'h3ff);
            end
        end
    endtask

    task automatic send_short(input logic [5:0] dt);
        @(negedge mipi_byte_clock);
        sp_enable = 1'b1;
        datatype  = dt;
        if (dt == camera_stream_pkg::DT_FRAME_END) frame_end_time = $time;
        @(negedge mipi_byte_clock);
        sp_enable = 1'b0;
    endtask

    task automatic send_line(input int row, input int nbytes, input logic [5:0] dt);
        @(negedge mipi_byte_clock);
        lp_av_enable = 1'b1;
        datatype     = dt;
        word_count   = 16'(nbytes);
        for (int b = 0; b < nbytes; b++) begin
            @(negedge mipi_byte_clock);
            lp_av_enable   = 1'b0;
            payload_enable = 1'b1;
            payload = (dt == camera_stream_pkg::DT_RAW10) ? line_byte(row, b) : 8'(b * 17 + 5);
            if (record_group && dt == camera_stream_pkg::DT_RAW10 && b == 4) begin
                group_time   = $time;  // Fifth byte of the first group
                record_group = 1'b0;
            end
        end
        @(negedge mipi_byte_clock);
        payload_enable = 1'b0;
        repeat (5) @(negedge mipi_byte_clock);
    endtask

    task automatic send_frame(input int width, input int height, input int other_row);
        send_short(camera_stream_pkg::DT_FRAME_START);
        repeat (2) @(negedge mipi_byte_clock);
        for (int r = 0; r < height; r++) begin
            if (r == other_row) send_line(0, 7, DT_EMBEDDED);
            send_line(r, width * 5 / 4, camera_stream_pkg::DT_RAW10);
        end
        send_short(camera_stream_pkg::DT_FRAME_END);
    endtask

    // Reference model of crop and meter
    task automatic build_expected(input int width, input int height);
        exp_data.delete();
        exp_last.delete();
        exp_sum   = 0;
        exp_count = 0;
        exp_peak  = 0;
        for (int y = int'(window.y_start); y < int'(window.y_end) && y < height; y++) begin
            for (int x = int'(window.x_start); x < int'(window.x_end) && x < width; x++) begin
                exp_data.push_back(image[y][x]);
                exp_last.push_back(x == int'(window.x_end) - 1);
                exp_sum   += image[y][x];
                exp_count += 1;
                if (image[y][x] > exp_peak) exp_peak = image[y][x];
            end
        end
    endtask

    task automatic run_frame(input int width, input int height, input int other_row,
                             input camera_stream_pkg::crop_window_t w, input bit check_first);
        window = w;
        got_data.delete();
        got_last.delete();
        ready_count    = 0;
        first_pix_time = 0;
        record_group   = 1'b1;
        build_expected(width, height);
        send_frame(width, height, other_row);
        while (ready_count == 0) @(negedge mipi_byte_clock);
        repeat (8) @(negedge mipi_byte_clock);
        check_value("pixel_o.pixel_valid beats", exp_data.size(), got_data.size());
        for (int i = 0; i < exp_data.size(); i++) begin
            check_value($sformatf("pixel_o.data[%0d]", i), exp_data[i], got_data[i]);
            check_value($sformatf("pixel_o.line_end[%0d]", i), exp_last[i], got_last[i]);
        end
        check_value("sum_o", exp_sum, sum);
        check_value("count_o", exp_count, count);
        check_value("peak_o", exp_peak, peak);
        check_value("meter_ready_o pulses", 1, ready_count);
        check_value("meter_ready_o delay ns", 4 * PERIOD, ready_time - frame_end_time);
        check_value("pixel_o.frame_valid fall delay ns", 3 * PERIOD, fv_fall_time - frame_end_time);
        if (check_first)
            check_value("pixel_o first pixel delay ns", 3 * PERIOD, first_pix_time - group_time);
    endtask

    task automatic idle_after_reset();
        repeat (3) @(negedge mipi_byte_clock);
        check_value("pixel_o.pixel_valid", 0, pix_out.pixel_valid);
        check_value("pixel_o.frame_valid", 0, pix_out.frame_valid);
        check_value("meter_ready_o", 0, meter_ready);
    endtask

    task automatic unpack_full_window();
        fill_image(1'b0);
        run_frame(8, 4, -1, make_window(0, 8, 0, 4), 1'b1);
    endtask

    task automatic crop_inner_window();
        run_frame(8, 4, -1, make_window(2, 6, 1, 3), 1'b0);
    endtask

    task automatic ignore_other_packet();
        run_frame(8, 4, 1, make_window(0, 8, 1, 3), 1'b0);
    endtask

    task automatic meter_known_peak();
        fill_image(1'b0);
        image[0][0] = 10'h3ff;  // Outside the window, must not set the peak
        image[2][3] = 10'h3fe;
        run_frame(8, 4, -1, make_window(1, 7, 1, 3), 1'b0);
    endtask

    task automatic random_back_to_back();
        fill_image(1'b1);
        run_frame(12, 6, -1, make_window(1, 11, 0, 6), 1'b0);
        fill_image(1'b1);
        run_frame(16, 5, -1, make_window(4, 16, 1, 4), 1'b0);
    endtask

    initial begin
        seed              = 41;
        mipi_byte_reset_n = 1'b0;
        sp_enable         = 1'b0;
        lp_av_enable      = 1'b0;
        payload_enable    = 1'b0;
        datatype          = 6'h00;
        word_count        = 16'd0;
        payload           = 8'h00;
        window            = make_window(0, 8, 0, 4);
        fv_seen           = 1'b0;
        repeat (4) @(negedge mipi_byte_clock);
        mipi_byte_reset_n = 1'b1;
        idle_after_reset();
        unpack_full_window();
        crop_inner_window();
        ignore_other_packet();
        meter_known_peak();
        random_back_to_back();
        $display("PASS: all tests");
        $finish;
    end

endmodule

//--- source/camera_stream_top.sv
// Top level of the camera receive path in the MIPI byte clock domain.
// Chains packet decoder, RAW10 unpacker, pan crop and exposure meter.
// The cropped pixel stream leaves on pixel_o and the meter results
// update once per frame with a ready pulse.

`timescale 1ns/1ps

module camera_stream_top #(
    parameter int SUM_WIDTH = 32
) (
    input  logic                                         mipi_byte_clock,
    input  logic                                         mipi_byte_reset_n,
    input  logic                                         sp_enable_i,
    input  logic                                         lp_av_enable_i,
    input  logic [5:0]                                   datatype_i,
    input  logic [15:0]                                  word_count_i,
    input  logic                                         payload_enable_i,
    input  logic [7:0]                                   payload_i,
    input  camera_stream_pkg::crop_window_t              crop_window_i,
    output camera_stream_pkg::pixel_beat_t               pixel_o,
    output logic [SUM_WIDTH-1:0]                         sum_o,
    output logic [camera_stream_pkg::COUNT_WIDTH-1:0]    count_o,
    output logic [9:0]                                   peak_o,
    output logic                                         meter_ready_o
);

    camera_stream_pkg::byte_beat_t  byte_beat;      // Decoder to unpacker
    camera_stream_pkg::pixel_beat_t unpacked_pixel; // Unpacker to crop

    csi2_packet_decoder csi2_packet_decoder_i (
        .mipi_byte_clock  (mipi_byte_clock),
        .mipi_byte_reset_n(mipi_byte_reset_n),
        .sp_enable_i      (sp_enable_i),
        .lp_av_enable_i   (lp_av_enable_i),
        .payload_enable_i (payload_enable_i),
        .datatype_i       (datatype_i),
        .word_count_i     (word_count_i),
        .payload_i        (payload_i),
        .byte_o           (byte_beat)
    );

    raw10_unpacker raw10_unpacker_i (
        .mipi_byte_clock  (mipi_byte_clock),
        .mipi_byte_reset_n(mipi_byte_reset_n),
        .byte_i           (byte_beat),
        .pixel_o          (unpacked_pixel)
    );

    pixel_crop pixel_crop_i (
        .mipi_byte_clock  (mipi_byte_clock),
        .mipi_byte_reset_n(mipi_byte_reset_n),
        .pixel_i          (unpacked_pixel),
        .window_i         (crop_window_i),
        .pixel_o          (pixel_o)
    );

    exposure_meter #(
        .SUM_WIDTH(SUM_WIDTH)
    ) exposure_meter_i (
        .mipi_byte_clock  (mipi_byte_clock),
        .mipi_byte_reset_n(mipi_byte_reset_n),
        .pixel_i          (pixel_o),
        .sum_o            (sum_o),
        .count_o          (count_o),
        .peak_o           (peak_o),
        .meter_ready_o    (meter_ready_o)
    );

endmodule

//--- source/exposure_meter.sv
// Exposure statistics over the cropped frame.
// Sums valid pixels, counts them and keeps the peak value. When the
// frame level falls the results are published, ready pulses for one
// cycle and the accumulators restart for the next frame.

`timescale 1ns/1ps

module exposure_meter #(
    parameter int SUM_WIDTH = 32
) (
    input  logic                                         mipi_byte_clock,
    input  logic                                         mipi_byte_reset_n,
    input  camera_stream_pkg::pixel_beat_t               pixel_i,
    output logic [SUM_WIDTH-1:0]                         sum_o,
    output logic [camera_stream_pkg::COUNT_WIDTH-1:0]    count_o,
    output logic [9:0]                                   peak_o,
    output logic                                         meter_ready_o
);

    logic                                      fv_prev;
    logic                                      frame_fall;
    logic [SUM_WIDTH-1:0]                      sum_acc;
    logic [camera_stream_pkg::COUNT_WIDTH-1:0] count_acc;
    logic [9:0]                                peak_acc;

    assign frame_fall = fv_prev && !pixel_i.frame_valid;

    always_ff @(posedge mipi_byte_clock or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            fv_prev       <= 1'b0;
            meter_ready_o <= 1'b0;
            sum_acc       <= '0;
            count_acc     <= '0;
            peak_acc      <= '0;
            sum_o         <= '0;
            count_o       <= '0;
            peak_o        <= '0;
        end else begin
            fv_prev       <= pixel_i.frame_valid;
            meter_ready_o <= frame_fall;
            if (frame_fall) begin
                sum_o     <= sum_acc;  // Held until the next frame end
                count_o   <= count_acc;
                peak_o    <= peak_acc;
                sum_acc   <= '0;
                count_acc <= '0;
                peak_acc  <= '0;
            end else if (pixel_i.pixel_valid) begin
                sum_acc   <= sum_acc + SUM_WIDTH'(pixel_i.data);
                count_acc <= count_acc + 1'b1;
                if (pixel_i.data > peak_acc) begin
                    peak_acc <= pixel_i.data;
                end
            end
        end
    end

endmodule

//--- source/pixel_crop.sv
// Pan window crop on the pixel stream.
// Tracks the column and row of each incoming pixel and forwards only
// pixels inside the window. Line end is moved to the last column of
// the window. Registered, one cycle of latency.

`timescale 1ns/1ps

module pixel_crop (
    input  logic                            mipi_byte_clock,
    input  logic                            mipi_byte_reset_n,
    input  camera_stream_pkg::pixel_beat_t  pixel_i,
    input  camera_stream_pkg::crop_window_t window_i,
    output camera_stream_pkg::pixel_beat_t  pixel_o
);

    localparam int CW = camera_stream_pkg::COORD_WIDTH;

    logic [CW-1:0] col_q;
    logic [CW-1:0] row_q;
    logic          fv_prev;
    logic          frame_rise;
    logic          in_x;
    logic          in_y;
    logic          last_col;
    logic          frame_valid_q;
    logic          pixel_valid_q;
    logic          line_end_q;
    logic [9:0]    data_q;

    assign frame_rise = pixel_i.frame_valid && !fv_prev;
    assign in_x       = (col_q >= window_i.x_start) && (col_q < window_i.x_end);
    assign in_y       = (row_q >= window_i.y_start) && (row_q < window_i.y_end);
    assign last_col   = (col_q == CW'(window_i.x_end - 1'b1));

    always_ff @(posedge mipi_byte_clock or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            fv_prev <= 1'b0;
            col_q   <= '0;
            row_q   <= '0;
        end else begin
            fv_prev <= pixel_i.frame_valid;
            if (frame_rise) begin
                col_q <= '0;
                row_q <= '0;
            end else if (pixel_i.pixel_valid) begin
                if (pixel_i.line_end) begin
                    col_q <= '0;
                    row_q <= row_q + 1'b1;
                end else begin
                    col_q <= col_q + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge mipi_byte_clock or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            frame_valid_q <= 1'b0;
            pixel_valid_q <= 1'b0;
            line_end_q    <= 1'b0;
        end else begin
            frame_valid_q <= pixel_i.frame_valid;
            pixel_valid_q <= pixel_i.pixel_valid && in_x && in_y;
            line_end_q    <= pixel_i.pixel_valid && in_y && last_col;
        end
    end

    always_ff @(posedge mipi_byte_clock) begin
        data_q <= pixel_i.data;
    end

    assign pixel_o = '{frame_valid: frame_valid_q, pixel_valid: pixel_valid_q,
                       line_end: line_end_q, data: data_q};

endmodule

//--- source/raw10_unpacker.sv
// Turns the RAW10 byte stream into 10-bit Bayer pixels.
// Five bytes make one group of four pixels. Once a group is complete
// its pixels leave on four consecutive cycles, pixel k appearing k+1
// cycles after the fifth byte.

`timescale 1ns/1ps

module raw10_unpacker (
    input  logic                            mipi_byte_clock,
    input  logic                            mipi_byte_reset_n,
    input  camera_stream_pkg::byte_beat_t   byte_i,
    output camera_stream_pkg::pixel_beat_t  pixel_o
);

    camera_stream_pkg::raw10_group_u group_q;
    camera_stream_pkg::raw10_group_u group_next;
    camera_stream_pkg::raw10_group_u hold_q;

    logic [2:0] byte_pos;     // Position of the next byte in the group
    logic       group_done;
    logic       hold_last;    // Held group ends the line
    logic       emit_active;
    logic [1:0] emit_idx;
    logic       frame_valid_q;

    assign group_done = byte_i.byte_valid && (byte_pos == 3'd4);

    // Current group with the incoming byte placed
    always_comb begin
        group_next = group_q;
        group_next.as_bytes[byte_pos] = byte_i.data;
    end

    always_ff @(posedge mipi_byte_clock) begin
        if (byte_i.byte_valid) begin
            group_q <= group_next;
        end
        if (group_done) begin
            hold_q <= group_next;
        end
    end

    always_ff @(posedge mipi_byte_clock or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            byte_pos <= 3'd0;
        end else if (!byte_i.frame_valid) begin
            byte_pos <= 3'd0;
        end else if (byte_i.byte_valid) begin
            if (group_done || byte_i.line_last) begin
                byte_pos <= 3'd0;  // Next line starts a fresh group
            end else begin
                byte_pos <= byte_pos + 3'd1;
            end
        end
    end

    always_ff @(posedge mipi_byte_clock or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            emit_active   <= 1'b0;
            emit_idx      <= 2'd0;
            hold_last     <= 1'b0;
            frame_valid_q <= 1'b0;
        end else begin
            frame_valid_q <= byte_i.frame_valid;  // Aligns with the first pixel
            if (group_done) begin
                emit_active <= 1'b1;
                emit_idx    <= 2'd0;
                hold_last   <= byte_i.line_last;
            end else if (emit_active) begin
                emit_idx <= emit_idx + 2'd1;
                if (emit_idx == 2'd3) begin
                    emit_active <= 1'b0;
                end
            end
        end
    end

    always_comb begin
        pixel_o.frame_valid = frame_valid_q;
        pixel_o.pixel_valid = emit_active;
        pixel_o.line_end    = emit_active && hold_last && (emit_idx == 2'd3);
        pixel_o.data        = {hold_q.as_fields.msbs[emit_idx],
                               hold_q.as_fields.lsbs[{emit_idx, 1'b0} +: 2]};
    end

    // Line width must be a whole number of groups
    a_line_on_group: assert property (
        @(posedge mipi_byte_clock) disable iff (!mipi_byte_reset_n)
        (byte_i.byte_valid && byte_i.line_last) |-> (byte_pos == 3'd4)
    ) else $error("line ended inside a RAW10 group");

endmodule

//--- source/csi2_packet_decoder.sv
// Input stage of the receive path.
// Takes the strobes of a CSI-2 receiver and produces a registered byte
// stream with a frame level and a marker on the last payload byte of
// each RAW10 line. Other long packets are consumed silently.

`timescale 1ns/1ps

module csi2_packet_decoder (
    input  logic                            mipi_byte_clock,
    input  logic                            mipi_byte_reset_n,
    input  logic                            sp_enable_i,
    input  logic                            lp_av_enable_i,
    input  logic                            payload_enable_i,
    input  logic [5:0]                      datatype_i,
    input  logic [15:0]                     word_count_i,
    input  logic [7:0]                      payload_i,
    output camera_stream_pkg::byte_beat_t   byte_o
);

    logic        frame_valid_q;
    logic        in_packet;    // Long packet payload still expected
    logic        is_raw10;
    logic [15:0] bytes_left;
    logic        accept;
    logic        byte_valid_q;
    logic        line_last_q;
    logic [7:0]  data_q;

    assign accept = payload_enable_i && in_packet;

    always_ff @(posedge mipi_byte_clock or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            frame_valid_q <= 1'b0;
        end else if (sp_enable_i) begin
            if (datatype_i == camera_stream_pkg::DT_FRAME_START) begin
                frame_valid_q <= 1'b1;
            end else if (datatype_i == camera_stream_pkg::DT_FRAME_END) begin
                frame_valid_q <= 1'b0;
            end
        end
    end

    // Long packet byte counter, loaded from the header
    always_ff @(posedge mipi_byte_clock or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            in_packet  <= 1'b0;
            is_raw10   <= 1'b0;
            bytes_left <= 16'd0;
        end else if (lp_av_enable_i) begin
            in_packet  <= (word_count_i != 16'd0);
            is_raw10   <= (datatype_i == camera_stream_pkg::DT_RAW10);
            bytes_left <= word_count_i;
        end else if (accept) begin
            bytes_left <= bytes_left - 16'd1;
            if (bytes_left == 16'd1) begin
                in_packet <= 1'b0;
            end
        end
    end

    always_ff @(posedge mipi_byte_clock or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            byte_valid_q <= 1'b0;
            line_last_q  <= 1'b0;
        end else begin
            byte_valid_q <= accept && is_raw10;  // Other types are dropped
            line_last_q  <= accept && is_raw10 && (bytes_left == 16'd1);
        end
    end

    always_ff @(posedge mipi_byte_clock) begin
        data_q <= payload_i;
    end

    always_comb begin
        byte_o.frame_valid = frame_valid_q;
        byte_o.byte_valid  = byte_valid_q;
        byte_o.line_last   = line_last_q;
        byte_o.data        = data_q;
    end

    // Payload must follow a header
    a_payload_in_packet: assert property (
        @(posedge mipi_byte_clock) disable iff (!mipi_byte_reset_n)
        $rose(payload_enable_i) |-> in_packet
    ) else $error("payload enable outside a long packet");

endmodule

//--- source/camera_stream_pkg.sv
// Shared types and constants for the camera receive path.
// Holds the stream structs passed between stages, the RAW10 group
// union and the CSI-2 data-type codes. Modules reference items by
// scoped name.

package camera_stream_pkg;

    localparam int COORD_WIDTH = 11;  // Column and row coordinates
    localparam int COUNT_WIDTH = 22;  // Meter pixel count

    // CSI-2 data-type codes
    localparam logic [5:0] DT_FRAME_START = 6'h00;
    localparam logic [5:0] DT_FRAME_END   = 6'h01;
    localparam logic [5:0] DT_RAW10       = 6'h2B;

    // Decoder to unpacker, one payload byte per strobe
    typedef struct packed {
        logic       frame_valid;  // Level
        logic       byte_valid;   // One-cycle strobe
        logic       line_last;    // Final payload byte of the line
        logic [7:0] data;
    } byte_beat_t;

    // RAW10 group seen as decoded fields
    // Pixel k has its two LSBs in lsbs[2k+1:2k]
    typedef struct packed {
        logic [7:0]      lsbs;  // Fifth byte on the wire
        logic [3:0][7:0] msbs;  // Pixel 0 MSB arrives first
    } raw10_fields_t;

    // Five RAW10 bytes, written in arrival order and read as fields
    typedef union packed {
        logic [4:0][7:0] as_bytes;  // Index 0 is the first byte received
        raw10_fields_t   as_fields;
    } raw10_group_u;

    // Pixel stream between unpacker, crop, meter and top output
    typedef struct packed {
        logic       frame_valid;  // Level
        logic       pixel_valid;  // Strobe
        logic       line_end;     // Last pixel of the line
        logic [9:0] data;
    } pixel_beat_t;

    // Pan window, start inclusive and end exclusive
    typedef struct packed {
        logic [COORD_WIDTH-1:0] x_start;
        logic [COORD_WIDTH-1:0] x_end;
        logic [COORD_WIDTH-1:0] y_start;
        logic [COORD_WIDTH-1:0] y_end;
    } crop_window_t;

endpackage
